/* Bender.yml */
package:
  name: axil_target_cluster

sources:
  - files:
      - rtl/axil_cluster_pkg.sv
      - rtl/axil_addr_demux.sv
      - rtl/axil_delay_target.sv
      - rtl/axil_target_cluster.sv
  - target: test
    files:
      - verification/tb_clk_gen.sv
      - verification/tb_axil_checker.sv
      - verification/tb_axil_cluster.sv

/* files.f */
rtl/axil_cluster_pkg.sv
rtl/axil_addr_demux.sv
rtl/axil_delay_target.sv
rtl/axil_target_cluster.sv
verification/tb_clk_gen.sv
verification/tb_axil_checker.sv
verification/tb_axil_cluster.sv

/* rtl/axil_addr_demux.sv */
// ##############################
// AXI4-Lite address demux
// Splits the window into four regions, keeps responses in order
// and answers out-of-window accesses with DECERR
// ##############################

`timescale 1ns/1ps

module axil_addr_demux import axil_cluster_pkg::*; #(
  parameter addr_t       BaseAddr   = 32'h1000,
  parameter int unsigned MemWords   = 16,
  parameter int unsigned MaxPending = 4
) (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  axil_req_t                  req_i,
  output axil_rsp_t                  rsp_o,
  output axil_req_t [NumTargets-1:0] tgt_req_o,
  input  axil_rsp_t [NumTargets-1:0] tgt_rsp_i
);

  localparam addr_t       RegionBytes = addr_t'(MemWords * 4);
  localparam addr_t       WindowBytes = addr_t'(MemWords * 4 * NumTargets);
  localparam int unsigned SelW        = $clog2(NumTargets + 1);
  localparam int unsigned CntW        = $clog2(MaxPending + 1);

  typedef logic [SelW-1:0] sel_t;
  typedef logic [CntW-1:0] cnt_t;

  // One index past the last target stands for the error responder
  localparam sel_t ErrSel = sel_t'(NumTargets);

  sel_t aw_dest, ar_dest, w_dest;
  sel_t wr_sel_q, rd_sel_q;
  cnt_t wr_cnt_q, rd_cnt_q;
  logic wr_busy, rd_busy;
  logic aw_ok, ar_ok, w_open;
  logic aw_hs, b_hs, ar_hs, r_hs;
  logic err_aw_hs, err_w_hs, err_b_hs, err_ar_hs, err_r_hs;
  logic err_live_q, err_aw_got_q, err_w_got_q, err_b_valid_q, err_r_valid_q;
  logic err_aw_ready, err_w_ready, err_ar_ready;

  function automatic sel_t decode(addr_t addr);
    addr_t offset;
    offset = addr - BaseAddr;
    if (addr < BaseAddr || offset >= WindowBytes) begin
      return ErrSel;
    end
    return sel_t'(offset / RegionBytes);
  endfunction

  function automatic cnt_t next_cnt(cnt_t cnt, logic inc, logic dec);
    if (inc && !dec) begin
      return cnt + 1'b1;
    end else if (dec && !inc) begin
      return cnt - 1'b1;
    end
    return cnt;
  endfunction

  assign aw_dest = decode(req_i.aw.addr);
  assign ar_dest = decode(req_i.ar.addr);
  assign wr_busy = wr_cnt_q != '0;
  assign rd_busy = rd_cnt_q != '0;

  // Stall a new region until the old one drains, or when full
  assign aw_ok = !wr_busy || ((aw_dest == wr_sel_q) && (wr_cnt_q < MaxPending));
  assign ar_ok = !rd_busy || ((ar_dest == rd_sel_q) && (rd_cnt_q < MaxPending));

  // W follows the oldest pending write, or an AW offered alongside it
  assign w_dest = wr_busy ? wr_sel_q : aw_dest;
  assign w_open = wr_busy || (req_i.aw_valid && aw_ok);

  assign err_aw_ready = err_live_q && !err_aw_got_q && !err_b_valid_q;
  assign err_w_ready  = err_live_q && !err_w_got_q && !err_b_valid_q;
  assign err_ar_ready = err_live_q && !err_r_valid_q;

  always_comb begin
    rsp_o = '0;
    for (int i = 0; i < NumTargets; i++) begin
      tgt_req_o[i]          = req_i;
      tgt_req_o[i].aw_valid = req_i.aw_valid && aw_ok && (aw_dest == sel_t'(i));
      tgt_req_o[i].w_valid  = req_i.w_valid && w_open && (w_dest == sel_t'(i));
      tgt_req_o[i].b_ready  = req_i.b_ready && wr_busy && (wr_sel_q == sel_t'(i));
      tgt_req_o[i].ar_valid = req_i.ar_valid && ar_ok && (ar_dest == sel_t'(i));
      tgt_req_o[i].r_ready  = req_i.r_ready && rd_busy && (rd_sel_q == sel_t'(i));
      if (aw_dest == sel_t'(i)) begin
        rsp_o.aw_ready = aw_ok && tgt_rsp_i[i].aw_ready;
      end
      if (w_dest == sel_t'(i)) begin
        rsp_o.w_ready = w_open && tgt_rsp_i[i].w_ready;
      end
      if (wr_busy && (wr_sel_q == sel_t'(i))) begin
        rsp_o.b       = tgt_rsp_i[i].b;
        rsp_o.b_valid = tgt_rsp_i[i].b_valid;
      end
      if (ar_dest == sel_t'(i)) begin
        rsp_o.ar_ready = ar_ok && tgt_rsp_i[i].ar_ready;
      end
      if (rd_busy && (rd_sel_q == sel_t'(i))) begin
        rsp_o.r       = tgt_rsp_i[i].r;
        rsp_o.r_valid = tgt_rsp_i[i].r_valid;
      end
    end
    if (aw_dest == ErrSel) begin
      rsp_o.aw_ready = aw_ok && err_aw_ready;
    end
    if (w_dest == ErrSel) begin
      rsp_o.w_ready = w_open && err_w_ready;
    end
    if (wr_busy && (wr_sel_q == ErrSel)) begin
      rsp_o.b_valid = err_b_valid_q;
      rsp_o.b.resp  = DECERR;
    end
    if (ar_dest == ErrSel) begin
      rsp_o.ar_ready = ar_ok && err_ar_ready;
    end
    if (rd_busy && (rd_sel_q == ErrSel)) begin
      rsp_o.r_valid = err_r_valid_q;
      rsp_o.r.data  = '0;
      rsp_o.r.resp  = DECERR;
    end
  end

  assign aw_hs = req_i.aw_valid && rsp_o.aw_ready;
  assign b_hs  = rsp_o.b_valid && req_i.b_ready;
  assign ar_hs = req_i.ar_valid && rsp_o.ar_ready;
  assign r_hs  = rsp_o.r_valid && req_i.r_ready;

  assign err_aw_hs = aw_hs && (aw_dest == ErrSel);
  assign err_w_hs  = req_i.w_valid && rsp_o.w_ready && (w_dest == ErrSel);
  assign err_b_hs  = b_hs && (wr_sel_q == ErrSel);
  assign err_ar_hs = ar_hs && (ar_dest == ErrSel);
  assign err_r_hs  = r_hs && (rd_sel_q == ErrSel);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_cnt_q <= '0;
      rd_cnt_q <= '0;
      wr_sel_q <= '0;
      rd_sel_q <= '0;
    end else begin
      wr_cnt_q <= next_cnt(wr_cnt_q, aw_hs, b_hs);
      rd_cnt_q <= next_cnt(rd_cnt_q, ar_hs, r_hs);
      if (aw_hs) begin
        wr_sel_q <= aw_dest;
      end
      if (ar_hs) begin
        rd_sel_q <= ar_dest;
      end
    end
  end

  // Decode error responder
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      err_live_q    <= 1'b0;
      err_aw_got_q  <= 1'b0;
      err_w_got_q   <= 1'b0;
      err_b_valid_q <= 1'b0;
      err_r_valid_q <= 1'b0;
    end else begin
      err_live_q <= 1'b1;
      if (err_b_valid_q) begin
        if (err_b_hs) begin
          err_b_valid_q <= 1'b0;
        end
      end else if ((err_aw_got_q || err_aw_hs) && (err_w_got_q || err_w_hs)) begin
        err_b_valid_q <= 1'b1;
        err_aw_got_q  <= 1'b0;
        err_w_got_q   <= 1'b0;
      end else begin
        if (err_aw_hs) begin
          err_aw_got_q <= 1'b1;
        end
        if (err_w_hs) begin
          err_w_got_q <= 1'b1;
        end
      end
      if (err_ar_hs) begin
        err_r_valid_q <= 1'b1;
      end else if (err_r_hs) begin
        err_r_valid_q <= 1'b0;
      end
    end
  end

  // A target may only answer what was routed to it
  for (genvar g = 0; g < NumTargets; g++) begin : gen_sel_checks
    a_b_from_selected: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      tgt_rsp_i[g].b_valid |-> wr_busy && (wr_sel_q == sel_t'(g)));
    a_r_from_selected: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      tgt_rsp_i[g].r_valid |-> rd_busy && (rd_sel_q == sel_t'(g)));
  end

  a_pending_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (wr_cnt_q <= MaxPending) && (rd_cnt_q <= MaxPending));

endmodule

/* rtl/axil_cluster_pkg.sv */
// ##############################
// AXI4-Lite target cluster types
// Channel payloads, request and response bundles, response codes
// and the wait bounds of slow and fast targets
// ##############################

package axil_cluster_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;

  // Only the codes this cluster can return
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    DECERR = 2'b11
  } resp_e;

  typedef enum logic [1:0] {
    SlowKind,
    FastKind,
    MixedKind
  } speed_kind_e;

  localparam int unsigned NumTargets = 4;

  // Wait bounds in cycles
  localparam int unsigned FastMinWait = 0;
  localparam int unsigned FastMaxWait = 5;
  localparam int unsigned SlowMinWait = 20;
  localparam int unsigned SlowMaxWait = 40;

  typedef struct packed {
    addr_t addr;
  } aw_chan_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
  } w_chan_t;

  typedef struct packed {
    resp_e resp;
  } b_chan_t;

  typedef struct packed {
    addr_t addr;
  } ar_chan_t;

  typedef struct packed {
    data_t data;
    resp_e resp;
  } r_chan_t;

  // Manager side
  typedef struct packed {
    aw_chan_t aw;
    logic     aw_valid;
    w_chan_t  w;
    logic     w_valid;
    logic     b_ready;
    ar_chan_t ar;
    logic     ar_valid;
    logic     r_ready;
  } axil_req_t;

  // Subordinate side
  typedef struct packed {
    logic     aw_ready;
    logic     w_ready;
    b_chan_t  b;
    logic     b_valid;
    logic     ar_ready;
    r_chan_t  r;
    logic     r_valid;
  } axil_rsp_t;

endpackage

/* rtl/axil_delay_target.sv */
// ##############################
// AXI4-Lite delay target
// Word memory with byte strobes, answers each write and read
// after a pseudo-random wait
// ##############################

`timescale 1ns/1ps

module axil_delay_target import axil_cluster_pkg::*; #(
  parameter int unsigned MemWords = 16,
  parameter int unsigned MinWait  = 0,
  parameter int unsigned MaxWait  = 5,
  parameter logic [15:0] LfsrSeed = 16'hace1
) (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  axil_req_t req_i,
  output axil_rsp_t rsp_o
);

  localparam int unsigned IdxW = (MemWords > 1) ? $clog2(MemWords) : 1;
  localparam int unsigned CntW = $clog2(MaxWait + 2);
  localparam int unsigned Span = MaxWait - MinWait + 1;

  typedef logic [IdxW-1:0] idx_t;
  typedef logic [CntW-1:0] cnt_t;

  typedef enum logic [1:0] {
    StInit,
    StIdle,
    StWait,
    StResp
  } state_e;

  state_e      wr_state_q, rd_state_q;
  logic [15:0] lfsr_q;
  cnt_t        wr_wait, rd_wait;
  cnt_t        wr_cnt_q, rd_cnt_q;
  logic        aw_got_q, w_got_q;
  logic        aw_hs, w_hs, ar_hs;
  logic        wr_start, wr_commit, rd_fetch;
  idx_t        wr_idx_q, rd_idx_q;
  data_t       wr_data_q, r_data_q;
  strb_t       wr_strb_q;
  data_t       mem_q [MemWords];

  // Full address comes in, wrap it into this region
  function automatic idx_t word_idx(addr_t addr);
    return idx_t'((addr >> 2) % MemWords);
  endfunction

  function automatic cnt_t pick_wait(logic [15:0] rnd);
    return cnt_t'(MinWait + (rnd % Span));
  endfunction

  function automatic data_t merge(data_t old_word, data_t new_word, strb_t strb);
    data_t res;
    res = old_word;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return res;
  endfunction

  // Taps 16, 14, 13, 11
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      lfsr_q <= LfsrSeed;
    end else begin
      lfsr_q <= {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
    end
  end

  assign wr_wait = pick_wait(lfsr_q);
  assign rd_wait = pick_wait({lfsr_q[7:0], lfsr_q[15:8]});

  always_comb begin
    rsp_o          = '0;
    rsp_o.aw_ready = (wr_state_q == StIdle) && !aw_got_q;
    rsp_o.w_ready  = (wr_state_q == StIdle) && !w_got_q;
    rsp_o.b_valid  = wr_state_q == StResp;
    rsp_o.b.resp   = OKAY;
    rsp_o.ar_ready = rd_state_q == StIdle;
    rsp_o.r_valid  = rd_state_q == StResp;
    rsp_o.r.data   = r_data_q;
    rsp_o.r.resp   = OKAY;
  end

  assign aw_hs     = req_i.aw_valid && rsp_o.aw_ready;
  assign w_hs      = req_i.w_valid && rsp_o.w_ready;
  assign ar_hs     = req_i.ar_valid && rsp_o.ar_ready;
  assign wr_start  = (wr_state_q == StIdle) && (aw_got_q || aw_hs) && (w_got_q || w_hs);
  assign wr_commit = (wr_state_q == StWait) && (wr_cnt_q == '0);
  assign rd_fetch  = (rd_state_q == StWait) && (rd_cnt_q == '0);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_state_q <= StInit;
      wr_cnt_q   <= '0;
      aw_got_q   <= 1'b0;
      w_got_q    <= 1'b0;
    end else begin
      case (wr_state_q)
        StInit: wr_state_q <= StIdle;
        StIdle: begin
          if (wr_start) begin
            wr_state_q <= StWait;
            wr_cnt_q   <= wr_wait;
            aw_got_q   <= 1'b0;
            w_got_q    <= 1'b0;
          end else begin
            if (aw_hs) begin
              aw_got_q <= 1'b1;
            end
            if (w_hs) begin
              w_got_q <= 1'b1;
            end
          end
        end
        StWait: begin
          if (wr_cnt_q == '0) begin
            wr_state_q <= StResp;
          end else begin
            wr_cnt_q <= wr_cnt_q - 1'b1;
          end
        end
        StResp: begin
          if (req_i.b_ready) begin
            wr_state_q <= StIdle;
          end
        end
        default: wr_state_q <= StInit;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rd_state_q <= StInit;
      rd_cnt_q   <= '0;
    end else begin
      case (rd_state_q)
        StInit: rd_state_q <= StIdle;
        StIdle: begin
          if (ar_hs) begin
            rd_state_q <= StWait;
            rd_cnt_q   <= rd_wait;
          end
        end
        StWait: begin
          if (rd_cnt_q == '0) begin
            rd_state_q <= StResp;
          end else begin
            rd_cnt_q <= rd_cnt_q - 1'b1;
          end
        end
        StResp: begin
          if (req_i.r_ready) begin
            rd_state_q <= StIdle;
          end
        end
        default: rd_state_q <= StInit;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (aw_hs) begin
      wr_idx_q <= word_idx(req_i.aw.addr);
    end
    if (w_hs) begin
      wr_data_q <= req_i.w.data;
      wr_strb_q <= req_i.w.strb;
    end
    if (ar_hs) begin
      rd_idx_q <= word_idx(req_i.ar.addr);
    end
    if (rd_fetch) begin
      r_data_q <= mem_q[rd_idx_q];
    end
  end

  // Write lands as the wait ends, before B is shown
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < MemWords; i++) begin
        mem_q[i] <= '0;
      end
    end else if (wr_commit) begin
      mem_q[wr_idx_q] <= merge(mem_q[wr_idx_q], wr_data_q, wr_strb_q);
    end
  end

  a_b_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rsp_o.b_valid && !req_i.b_ready |=> rsp_o.b_valid && $stable(rsp_o.b));
  a_r_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rsp_o.r_valid && !req_i.r_ready |=> rsp_o.r_valid && $stable(rsp_o.r));

endmodule

/* rtl/axil_target_cluster.sv */
// ##############################
// AXI4-Lite target cluster
// Demux in front of four delay targets, waits set by speed kind
// ##############################

`timescale 1ns/1ps

module axil_target_cluster import axil_cluster_pkg::*; #(
  parameter addr_t       BaseAddr   = 32'h1000,
  parameter int unsigned MemWords   = 16,
  parameter int unsigned MaxPending = 4,
  parameter speed_kind_e SpeedKind  = MixedKind
) (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  axil_req_t req_i,
  output axil_rsp_t rsp_o
);

  axil_req_t [NumTargets-1:0] tgt_req;
  axil_rsp_t [NumTargets-1:0] tgt_rsp;

  axil_addr_demux #(
    .BaseAddr   (BaseAddr),
    .MemWords   (MemWords),
    .MaxPending (MaxPending)
  ) i_demux (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .req_i     (req_i),
    .rsp_o     (rsp_o),
    .tgt_req_o (tgt_req),
    .tgt_rsp_i (tgt_rsp)
  );

  for (genvar i = 0; i < NumTargets; i++) begin : gen_targets
    // Even regions slow and odd regions fast in the mixed kind
    localparam bit IsSlow = (SpeedKind == SlowKind) ||
                            ((SpeedKind == MixedKind) && (i % 2 == 0));
    localparam int unsigned MinWait = IsSlow ? SlowMinWait : FastMinWait;
    localparam int unsigned MaxWait = IsSlow ? SlowMaxWait : FastMaxWait;
    localparam logic [15:0] Seed    = 16'hace1 + 16'(i * 16'h3b5);

    axil_delay_target #(
      .MemWords (MemWords),
      .MinWait  (MinWait),
      .MaxWait  (MaxWait),
      .LfsrSeed (Seed)
    ) i_target (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .req_i   (tgt_req[i]),
      .rsp_o   (tgt_rsp[i])
    );
  end

endmodule

/* verification/tb_axil_checker.sv */
// ##############################
// AXI4-Lite cluster checker
// Reference memory, response, stability
// and latency checks
// ##############################

`timescale 1ns/1ps

module tb_axil_checker import axil_cluster_pkg::*; #(
  parameter addr_t       BaseAddr  = 32'h1000,
  parameter int unsigned MemWords  = 16,
  parameter speed_kind_e SpeedKind = MixedKind
) (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  axil_req_t   req_i,
  input  axil_rsp_t   rsp_i,
  input  resp_e       exp_resp_i,
  input  logic        done_i,
  output int unsigned value_errs_o,
  output int unsigned proto_errs_o,
  output int unsigned timing_errs_o
);

  localparam int unsigned RegionBytes = MemWords * 4;

  int unsigned value_errs  = 0;
  int unsigned proto_errs  = 0;
  int unsigned timing_errs = 0;
  data_t       ref_mem [NumTargets * MemWords];
  addr_t       wr_addr, rd_addr;
  data_t       wr_data, exp_data;
  strb_t       wr_strb;
  logic        aw_seen, w_seen, wr_open, rd_open, wr_rose, rd_rose;
  logic        b_held, r_held, final_done;
  b_chan_t     b_prev;
  r_chan_t     r_prev;
  longint      cycle, wr_t0, rd_t0;

  assign value_errs_o  = value_errs;
  assign proto_errs_o  = proto_errs;
  assign timing_errs_o = timing_errs;

  function automatic logic in_window(addr_t addr);
    return (addr >= BaseAddr) && ((addr - BaseAddr) < NumTargets * RegionBytes);
  endfunction

  function automatic int unsigned ref_index(addr_t addr);
    return (addr - BaseAddr) >> 2;
  endfunction

  // One byte lane of ones per set strobe
  function automatic data_t strobe_mask(strb_t strb);
    return {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
  endfunction

  task automatic report_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
    $display("FAILED t=%0t %s got=%0h exp=%0h", $time, name, got, exp);
    value_errs++;
  endtask

  // Target valid rises on the edge that ends the wait, seen one edge later
  task automatic check_latency(input string dir, input addr_t addr, input longint elapsed);
    longint lo, hi, measured;
    logic   slow;
    slow = (SpeedKind == SlowKind) ||
           ((SpeedKind == MixedKind) && (((addr - BaseAddr) / RegionBytes) % 2 == 0));
    if (!in_window(addr)) begin
      lo       = 1;
      hi       = 1;
      measured = elapsed;
    end else begin
      lo       = slow ? SlowMinWait + 1 : FastMinWait + 1;
      hi       = slow ? SlowMaxWait + 1 : FastMaxWait + 1;
      measured = elapsed - 1;
    end
    if (measured < lo || measured > hi) begin
      $display("%s to %h answered after %0d cycles at %0t, expected %0d to %0d",
               dir, addr, measured, $time, lo, hi);
      timing_errs++;
    end
  endtask

  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      if (rsp_i.aw_ready || rsp_i.w_ready || rsp_i.b_valid || rsp_i.ar_ready ||
          rsp_i.r_valid) begin
        $display("A valid or ready output is high during reset at %0t", $time);
        proto_errs++;
      end
      for (int i = 0; i < NumTargets * MemWords; i++) begin
        ref_mem[i] = '0;
      end
      {aw_seen, w_seen, wr_open, rd_open, wr_rose, rd_rose} = '0;
      {b_held, r_held, final_done} = '0;
      cycle = 0;
    end else begin
      cycle++;
      // Held responses must not change before they are taken
      if (b_held && !rsp_i.b_valid) begin
        $display("B valid dropped at %0t before it was accepted", $time);
        proto_errs++;
      end else if (b_held && rsp_i.b != b_prev) begin
        report_value("b", rsp_i.b, b_prev);
      end
      if (r_held && !rsp_i.r_valid) begin
        $display("R valid dropped at %0t before it was accepted", $time);
        proto_errs++;
      end else if (r_held && rsp_i.r != r_prev) begin
        report_value("r", rsp_i.r, r_prev);
      end
      if (rsp_i.b_valid && !wr_open) begin
        $display("B valid at %0t with no write pending", $time);
        proto_errs++;
      end
      if (rsp_i.r_valid && !rd_open) begin
        $display("R valid at %0t with no read pending", $time);
        proto_errs++;
      end
      if (wr_open && !wr_rose && rsp_i.b_valid) begin
        wr_rose = 1'b1;
        check_latency("Write", wr_addr, cycle - wr_t0);
      end
      if (rd_open && !rd_rose && rsp_i.r_valid) begin
        rd_rose = 1'b1;
        check_latency("Read", rd_addr, cycle - rd_t0);
      end
      if (rsp_i.b_valid && req_i.b_ready && wr_open) begin
        if (rsp_i.b.resp != exp_resp_i) begin
          report_value("b.resp", rsp_i.b.resp, exp_resp_i);
        end
        if (rsp_i.b.resp == OKAY && in_window(wr_addr)) begin
          ref_mem[ref_index(wr_addr)] = (ref_mem[ref_index(wr_addr)] & ~strobe_mask(wr_strb)) |
                                        (wr_data & strobe_mask(wr_strb));
        end
        wr_open = 1'b0;
      end
      if (rsp_i.r_valid && req_i.r_ready && rd_open) begin
        exp_data = '0;
        if (exp_resp_i == OKAY && in_window(rd_addr)) begin
          exp_data = ref_mem[ref_index(rd_addr)];
        end
        if (rsp_i.r.resp != exp_resp_i) begin
          report_value("r.resp", rsp_i.r.resp, exp_resp_i);
        end
        if (rsp_i.r.data != exp_data) begin
          report_value("r.data", rsp_i.r.data, exp_data);
        end
        rd_open = 1'b0;
      end
      if (req_i.aw_valid && rsp_i.aw_ready) begin
        wr_addr = req_i.aw.addr;
        aw_seen = 1'b1;
      end
      if (req_i.w_valid && rsp_i.w_ready) begin
        wr_data = req_i.w.data;
        wr_strb = req_i.w.strb;
        w_seen  = 1'b1;
      end
      // Latency counts from the later of AW and W
      if (aw_seen && w_seen) begin
        {wr_open, wr_rose, aw_seen, w_seen} = 4'b1000;
        wr_t0 = cycle;
      end
      if (req_i.ar_valid && rsp_i.ar_ready) begin
        rd_addr = req_i.ar.addr;
        {rd_open, rd_rose} = 2'b10;
        rd_t0 = cycle;
      end
      b_held = rsp_i.b_valid && !req_i.b_ready;
      b_prev = rsp_i.b;
      r_held = rsp_i.r_valid && !req_i.r_ready;
      r_prev = rsp_i.r;
      if (done_i && !final_done) begin
        final_done = 1'b1;
        if (wr_open) begin
          $display("Write to %h was accepted but never answered", wr_addr);
          proto_errs++;
        end
        if (rd_open) begin
          $display("Read of %h was accepted but never answered", rd_addr);
          proto_errs++;
        end
      end
    end
  end

endmodule

/* verification/tb_axil_cluster.sv */
// ##############################
// AXI4-Lite cluster testbench
// Applies a table of reads and writes to the cluster
// ##############################

`timescale 1ns/1ps

module tb_axil_cluster import axil_cluster_pkg::*; ();

  localparam addr_t       BaseAddr    = 32'h1000;
  localparam int unsigned MemWords    = 16;
  localparam int unsigned MaxPending  = 4;
  localparam int unsigned RegionBytes = MemWords * 4;
  localparam int unsigned Timeout     = 100;
  localparam logic        Wr          = 1'b1;
  localparam logic        Rd          = 1'b0;

  typedef struct packed {
    logic       is_write;
    addr_t      addr;
    data_t      data;
    strb_t      strb;
    resp_e      resp;
    logic [7:0] hold;
  } entry_t;

  logic        clk, rst_n, done;
  axil_req_t   req;
  axil_rsp_t   rsp;
  resp_e       exp_resp;
  int unsigned value_errs, proto_errs, timing_errs;
  int unsigned timeouts;
  entry_t      stim_q [$];

  tb_clk_gen i_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  axil_target_cluster #(
    .BaseAddr   (BaseAddr),
    .MemWords   (MemWords),
    .MaxPending (MaxPending),
    .SpeedKind  (MixedKind)
  ) DUT (
    .clk_i   (clk),
    .rst_n_i (rst_n),
    .req_i   (req),
    .rsp_o   (rsp)
  );

  tb_axil_checker #(
    .BaseAddr  (BaseAddr),
    .MemWords  (MemWords),
    .SpeedKind (MixedKind)
  ) i_checker (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .req_i         (req),
    .rsp_i         (rsp),
    .exp_resp_i    (exp_resp),
    .done_i        (done),
    .value_errs_o  (value_errs),
    .proto_errs_o  (proto_errs),
    .timing_errs_o (timing_errs)
  );

  task automatic add_entry(input logic is_write, input addr_t addr, input data_t data,
                           input strb_t strb, input resp_e resp, input int unsigned hold);
    entry_t e;
    e.is_write = is_write;
    e.addr     = addr;
    e.data     = data;
    e.strb     = strb;
    e.resp     = resp;
    e.hold     = 8'(hold);
    stim_q.push_back(e);
  endtask

  task automatic fill_table();
    addr_t first, last;
    // Fresh memory reads as zero
    for (int k = 0; k < NumTargets; k++) begin
      add_entry(Rd, BaseAddr + k * RegionBytes + 4 * k, '0, '0, OKAY, 0);
    end
    // First and last word of every region
    for (int k = 0; k < NumTargets; k++) begin
      first = BaseAddr + k * RegionBytes;
      last  = first + RegionBytes - 4;
      add_entry(Wr, first, {8'h5a, 8'(k), first[15:0]}, 4'hf, OKAY, 0);
      add_entry(Wr, last, {8'ha5, 8'(k), last[15:0]}, 4'hf, OKAY, k);
    end
    for (int k = 0; k < NumTargets; k++) begin
      first = BaseAddr + k * RegionBytes;
      add_entry(Rd, first, '0, '0, OKAY, k);
      add_entry(Rd, first + RegionBytes - 4, '0, '0, OKAY, 0);
    end
    // Partial strobes
    add_entry(Wr, 32'h1004, 32'h1122_3344, 4'hf, OKAY, 0);
    add_entry(Wr, 32'h1004, 32'haabb_ccdd, 4'b0101, OKAY, 2);
    add_entry(Rd, 32'h1004, '0, '0, OKAY, 0);
    add_entry(Wr, 32'h1048, 32'hdead_beef, 4'b1000, OKAY, 0);
    add_entry(Rd, 32'h1048, '0, '0, OKAY, 5);
    add_entry(Wr, 32'h10c0, 32'h0000_7700, 4'b0010, OKAY, 0);
    add_entry(Rd, 32'h10c0, '0, '0, OKAY, 0);
    // Out of window on both sides
    add_entry(Wr, 32'h0ffc, 32'hffff_ffff, 4'hf, DECERR, 3);
    add_entry(Rd, 32'h0ffc, '0, '0, DECERR, 0);
    add_entry(Wr, 32'h1100, 32'hffff_ffff, 4'hf, DECERR, 0);
    add_entry(Rd, 32'h1100, '0, '0, DECERR, 4);
    add_entry(Wr, 32'h8000_0000, 32'h0f0f_0f0f, 4'hf, DECERR, 0);
    add_entry(Rd, 32'h1000, '0, '0, OKAY, 0);
    add_entry(Rd, 32'h10fc, '0, '0, OKAY, 0);
    // Long back-pressure on slow and fast regions
    add_entry(Wr, 32'h1080, 32'h0bad_f00d, 4'hf, OKAY, 8);
    add_entry(Rd, 32'h1080, '0, '0, OKAY, 8);
    add_entry(Wr, 32'h10c4, 32'h7e57_1234, 4'hf, OKAY, 6);
    add_entry(Rd, 32'h10c4, '0, '0, OKAY, 7);
  endtask

  // Waits for B or R, holds ready low, then takes it
  task automatic take_response(input logic is_write, input int unsigned hold,
                               output logic ok);
    int unsigned n;
    logic        seen;
    seen = 1'b0;
    n    = 0;
    while (!seen && n < Timeout) begin
      @(posedge clk);
      seen = is_write ? rsp.b_valid : rsp.r_valid;
      n++;
    end
    if (!seen) begin
      $display("Timeout: no %s response arrived", is_write ? "write" : "read");
    end else begin
      repeat (hold + 1) @(negedge clk);
      req.b_ready = is_write;
      req.r_ready = !is_write;
      seen = 1'b0;
      n    = 0;
      while (!seen && n < Timeout) begin
        @(posedge clk);
        seen = is_write ? (rsp.b_valid && req.b_ready) : (rsp.r_valid && req.r_ready);
        n++;
      end
      @(negedge clk);
      req.b_ready = 1'b0;
      req.r_ready = 1'b0;
      if (!seen) begin
        $display("Timeout: response was not accepted");
      end
    end
    ok = seen;
  endtask

  task automatic send_write(input entry_t e, output logic ok);
    int unsigned n;
    logic        aw_done, w_done;
    aw_done = 1'b0;
    w_done  = 1'b0;
    n       = 0;
    @(negedge clk);
    exp_resp     = e.resp;
    req.aw.addr  = e.addr;
    req.aw_valid = 1'b1;
    req.w.data   = e.data;
    req.w.strb   = e.strb;
    req.w_valid  = 1'b1;
    while (!(aw_done && w_done) && n < Timeout) begin
      @(posedge clk);
      aw_done = aw_done || (req.aw_valid && rsp.aw_ready);
      w_done  = w_done || (req.w_valid && rsp.w_ready);
      @(negedge clk);
      req.aw_valid = !aw_done;
      req.w_valid  = !w_done;
      n++;
    end
    if (!(aw_done && w_done)) begin
      $display("Timeout: write to %h was not accepted", e.addr);
      ok = 1'b0;
    end else begin
      take_response(1'b1, e.hold, ok);
    end
  endtask

  task automatic send_read(input entry_t e, output logic ok);
    int unsigned n;
    logic        ar_done;
    ar_done = 1'b0;
    n       = 0;
    @(negedge clk);
    exp_resp     = e.resp;
    req.ar.addr  = e.addr;
    req.ar_valid = 1'b1;
    while (!ar_done && n < Timeout) begin
      @(posedge clk);
      ar_done = req.ar_valid && rsp.ar_ready;
      @(negedge clk);
      req.ar_valid = !ar_done;
      n++;
    end
    if (!ar_done) begin
      $display("Timeout: read of %h was not accepted", e.addr);
      ok = 1'b0;
    end else begin
      take_response(1'b0, e.hold, ok);
    end
  endtask

  initial begin
    entry_t      e;
    int unsigned n;
    logic        ok;
    req       = '0;
    exp_resp  = OKAY;
    done      = 1'b0;
    timeouts  = 0;
    ok        = 1'b1;
    void'($urandom(32'hf82ae971));
    fill_table();
    n = 0;
    while (!rst_n && n < Timeout) begin
      @(negedge clk);
      n++;
    end
    if (!rst_n) begin
      $display("Timeout: reset was never released");
      ok = 1'b0;
      timeouts++;
    end
    for (int i = 0; i < stim_q.size() && ok; i++) begin
      e = stim_q[i];
      // Short random idle gap between transactions
      repeat ($urandom_range(2, 0)) @(negedge clk);
      if (e.is_write) begin
        send_write(e, ok);
      end else begin
        send_read(e, ok);
      end
      if (!ok) begin
        timeouts++;
      end
    end
    @(negedge clk);
    done = 1'b1;
    repeat (2) @(negedge clk);
    $display("Errors: value %0d, protocol %0d, timing %0d, timeout %0d",
             value_errs, proto_errs, timing_errs, timeouts);
    if (value_errs + proto_errs + timing_errs + timeouts == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* verification/tb_clk_gen.sv */
// ##############################
// Testbench clock and reset
// 40 ns clock, reset held low for 10 cycles
// ##############################

`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int unsigned HalfPeriod  = 20,
  parameter int unsigned ResetCycles = 10
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(HalfPeriod) clk_o = ~clk_o;
  end

  // Release on a falling edge, away from the flops
  initial begin
    rst_n_o = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule
